// File: sources.f
design/mist_video_pkg.sv
design/osd_window.sv
design/osd_channel.sv
design/video_encoder.sv
design/mist_video_out.sv
testbench/mist_video_out_props.sv
testbench/tb_mist_video_out.sv

// File: testbench/tb_mist_video_out.sv
//****************************************
// tb_mist_video_out
// directed tests of the video output path
// against a queue based reference model
//****************************************

module tb_mist_video_out;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int          CW         = 4;
    localparam int          WIN_X      = 8;
    localparam int          WIN_Y      = 4;
    localparam int          VW         = mist_video_pkg::VID_W;
    localparam int          WAIT_LIMIT = 200;
    localparam logic [31:0] SEED       = 32'he14edcfb;

    typedef struct packed {
        logic [VW-1:0] r;
        logic [VW-1:0] g;
        logic [VW-1:0] b;
        logic          hs;
        logic          vs;
        logic [31:0]   cyc;
    } exp_pixel_t;

    logic                             clk;
    logic                             rst;
    logic                             in_valid;
    logic                             in_ready;
    logic [CW-1:0]                    in_r;
    logic [CW-1:0]                    in_g;
    logic [CW-1:0]                    in_b;
    logic                             in_hs;
    logic                             in_vs;
    mist_video_pkg::out_mode_e        out_mode;
    logic                             csync;
    logic                             osd_enable;
    logic                             osd_wr;
    logic [mist_video_pkg::OSD_ROW_W-1:0] osd_row;
    logic [mist_video_pkg::OSD_W-1:0] osd_bits;
    logic                             out_valid;
    logic                             out_ready;
    logic [VW-1:0]                    out_r;
    logic [VW-1:0]                    out_g;
    logic [VW-1:0]                    out_b;
    logic                             out_hs;
    logic                             out_vs;

    // model state
    logic [mist_video_pkg::OSD_W-1:0] bitmap_m [mist_video_pkg::OSD_H];
    exp_pixel_t                       exp_q [$];
    int                               x_m;
    int                               y_m;
    logic [31:0]                      rng;
    logic [31:0]                      cyc;
    logic                             lat_check;
    logic                             stream_done;
    int                               errors;
    int                               checks;

    mist_video_out #(
        .OSD_X (WIN_X),
        .OSD_Y (WIN_Y)
    ) i_mist_video_out (
        .clk_sys      (clk),
        .rst_i        (rst),
        .in_valid_i   (in_valid),
        .in_ready_o   (in_ready),
        .in_r_i       (in_r),
        .in_g_i       (in_g),
        .in_b_i       (in_b),
        .in_hs_i      (in_hs),
        .in_vs_i      (in_vs),
        .out_mode_i   (out_mode),
        .csync_i      (csync),
        .osd_enable_i (osd_enable),
        .osd_wr_i     (osd_wr),
        .osd_row_i    (osd_row),
        .osd_bits_i   (osd_bits),
        .out_valid_o  (out_valid),
        .out_ready_i  (out_ready),
        .out_r_o      (out_r),
        .out_g_o      (out_g),
        .out_b_o      (out_b),
        .out_hs_o     (out_hs),
        .out_vs_o     (out_vs)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] v;
        v = s ^ (s << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    function automatic logic [31:0] next_random();
        rng = xorshift32(rng);
        return rng;
    endfunction

    // repeat the top bits of the component down to 6 bits
    function automatic logic [VW-1:0] widen(input logic [CW-1:0] c);
        logic [VW-1:0] w;
        for (int i = 0; i < VW; i++) begin
            w[VW-1-i] = c[CW-1-(i % CW)];
        end
        return w;
    endfunction

    function automatic logic [VW-1:0] overlay(input logic [VW-1:0] w, input logic hit,
                                              input logic obit, input logic [VW-1:0] tint);
        if (hit && obit) begin
            return tint;
        end
        return hit ? (w >> 1) : w;
    endfunction

    function automatic logic [VW-1:0] clamp_range(input int v);
        return (v < 0) ? 6'd0 : (v > 63) ? 6'd63 : v[VW-1:0];
    endfunction

    function automatic exp_pixel_t build_expected(input logic [CW-1:0] r, input logic [CW-1:0] g,
                                                  input logic [CW-1:0] b, input logic hs,
                                                  input logic vs);
        exp_pixel_t    e;
        logic          hit;
        logic          obit;
        logic [VW-1:0] wr;
        logic [VW-1:0] wg;
        logic [VW-1:0] wb;
        int            yv;
        hit = osd_enable && x_m >= WIN_X && x_m < WIN_X + mist_video_pkg::OSD_W &&
              y_m >= WIN_Y && y_m < WIN_Y + mist_video_pkg::OSD_H;
        obit = hit ? bitmap_m[y_m - WIN_Y][x_m - WIN_X] : 1'b0;
        wr = overlay(widen(r), hit, obit, mist_video_pkg::OSD_TINT_R);
        wg = overlay(widen(g), hit, obit, mist_video_pkg::OSD_TINT_G);
        wb = overlay(widen(b), hit, obit, mist_video_pkg::OSD_TINT_B);
        if (out_mode == mist_video_pkg::MODE_YPBPR) begin
            yv  = (2 * int'(wr) + 5 * int'(wg) + int'(wb)) / 8;
            e.r = clamp_range(32 + ((int'(wr) - yv) >>> 1));
            e.g = yv[VW-1:0];
            e.b = clamp_range(32 + ((int'(wb) - yv) >>> 1));
        end else begin
            e.r = wr;
            e.g = wg;
            e.b = wb;
        end
        if (out_mode == mist_video_pkg::MODE_YPBPR || csync) begin
            e.hs = ~(hs ^ vs);
            e.vs = 1'b1;
        end else begin
            e.hs = hs;
            e.vs = vs;
        end
        e.cyc = cyc;
        return e;
    endfunction

    task automatic check_pixel(input string name, input logic [VW-1:0] got,
                               input logic [VW-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_sync(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_latency(input int got);
        checks++;
        if (got != 3) begin
            errors++;
            $display("Mismatch at %0t: latency got %0d expected 3", $time, got);
        end
    endtask

    task automatic report_timeout(input string why);
        errors++;
        $display("timeout at %0t: %s", $time, why);
    endtask

    // output monitor, one model entry per output transfer
    always @(posedge clk) begin
        exp_pixel_t e;
        if (!rst) begin
            if (!in_ready && !(out_valid && !out_ready)) begin
                errors++;
                $display("in_ready_o was low at %0t while the output was not stalled", $time);
            end
            if (out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("an output pixel at %0t had no matching input pixel", $time);
                end else begin
                    e = exp_q.pop_front();
                    check_pixel("out_r_o", out_r, e.r);
                    check_pixel("out_g_o", out_g, e.g);
                    check_pixel("out_b_o", out_b, e.b);
                    check_sync("out_hs_o", out_hs, e.hs);
                    check_sync("out_vs_o", out_vs, e.vs);
                    if (lat_check) begin
                        check_latency(int'(cyc - e.cyc));
                    end
                end
            end
        end
    end

    task automatic send_pixel(input logic [CW-1:0] r, input logic [CW-1:0] g,
                              input logic [CW-1:0] b, input logic hs, input logic vs);
        int waited;
        @(negedge clk);
        in_valid = 1'b1;
        in_r     = r;
        in_g     = g;
        in_b     = b;
        in_hs    = hs;
        in_vs    = vs;
        waited   = 0;
        do begin
            @(posedge clk);
            waited++;
        end while (!in_ready && waited < WAIT_LIMIT);
        if (!in_ready) begin
            report_timeout("in_ready_o never rose for a waiting pixel");
        end else begin
            exp_q.push_back(build_expected(r, g, b, hs, vs));
            // model position update
            x_m = hs ? 0 : x_m + 1;
            y_m = vs ? 0 : (hs ? y_m + 1 : y_m);
        end
    endtask

    task automatic send_random(input logic hs, input logic vs);
        logic [31:0] rv;
        rv = next_random();
        send_pixel(rv[3:0], rv[7:4], rv[11:8], hs, vs);
    endtask

    task automatic drain(input string name);
        int waited;
        @(negedge clk);
        in_valid = 1'b0;
        waited   = 0;
        while (exp_q.size() != 0 && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            report_timeout("expected pixels never left the output");
            exp_q.delete();
        end
        $display("test %s finished, %0d errors so far", name, errors);
    endtask

    task automatic run_single();
        @(posedge clk);
        check_sync("out_valid_o", out_valid, 1'b0);
        lat_check = 1'b1;
        send_pixel(4'h9, 4'h3, 4'he, 1'b0, 1'b0);
        drain("single_pixel");
        lat_check = 1'b0;
    endtask

    task automatic run_overlay();
        logic [31:0] rv;
        for (int row = 0; row < mist_video_pkg::OSD_H; row++) begin
            rv = next_random();
            @(negedge clk);
            osd_wr        = 1'b1;
            osd_row       = row[mist_video_pkg::OSD_ROW_W-1:0];
            osd_bits      = rv[15:0];
            bitmap_m[row] = rv[15:0];
        end
        @(negedge clk);
        osd_wr     = 1'b0;
        osd_enable = 1'b1;
        // frame start puts the next pixel at the origin
        send_pixel(4'h0, 4'h0, 4'h0, 1'b1, 1'b1);
        for (int line = 0; line < 14; line++) begin
            for (int px = 0; px < 28; px++) begin
                send_random(px == 27, 1'b0);
            end
        end
        drain("osd_overlay");
        osd_enable = 1'b0;
    endtask

    task automatic run_ypbpr();
        logic [31:0] rv;
        @(negedge clk);
        out_mode = mist_video_pkg::MODE_YPBPR;
        send_pixel(4'h0, 4'h0, 4'h0, 1'b0, 1'b0);
        send_pixel(4'hf, 4'hf, 4'hf, 1'b1, 1'b0);
        send_pixel(4'hf, 4'h0, 4'h0, 1'b0, 1'b1);
        send_pixel(4'h0, 4'h0, 4'hf, 1'b1, 1'b1);
        send_pixel(4'h0, 4'hf, 4'h0, 1'b0, 1'b0);
        send_pixel(4'hf, 4'h0, 4'hf, 1'b0, 1'b0);
        for (int i = 0; i < 30; i++) begin
            rv = next_random();
            send_random(rv[20], rv[21]);
        end
        drain("ypbpr");
        out_mode = mist_video_pkg::MODE_RGB;
    endtask

    task automatic run_csync();
        logic [31:0] rv;
        @(negedge clk);
        csync = 1'b1;
        for (int i = 0; i < 30; i++) begin
            rv = next_random();
            send_random(rv[5], rv[9]);
        end
        drain("composite_sync");
        csync = 1'b0;
    endtask

    task automatic run_backpressure();
        logic [31:0] st;
        st          = SEED ^ 32'h5a5a5a5a;
        stream_done = 1'b0;
        fork
            begin
                for (int i = 0; i < 40; i++) begin
                    send_random(i % 10 == 9, 1'b0);
                end
                stream_done = 1'b1;
            end
            // sink stalls about half of the cycles
            while (!stream_done) begin
                @(negedge clk);
                st        = xorshift32(st);
                out_ready = st[7];
            end
        join
        @(negedge clk);
        out_ready = 1'b1;
        drain("backpressure");
    endtask

    initial begin
        rst         = 1'b1;
        in_valid    = 1'b0;
        in_r        = '0;
        in_g        = '0;
        in_b        = '0;
        in_hs       = 1'b0;
        in_vs       = 1'b0;
        out_mode    = mist_video_pkg::MODE_RGB;
        csync       = 1'b0;
        osd_enable  = 1'b0;
        osd_wr      = 1'b0;
        osd_row     = '0;
        osd_bits    = '0;
        out_ready   = 1'b1;
        cyc         = '0;
        rng         = SEED;
        x_m         = 0;
        y_m         = 0;
        lat_check   = 1'b0;
        stream_done = 1'b0;
        errors      = 0;
        checks      = 0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        run_single();
        run_overlay();
        run_ypbpr();
        run_csync();
        run_backpressure();

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: testbench/mist_video_out_props.sv
//****************************************
// mist_video_out properties
// output handshake stability and reset
// values of the stream handshake
//****************************************

module mist_video_out_props (
    input logic                             clk_sys,
    input logic                             rst_i,
    input logic                             in_ready_o,
    input logic                             out_valid_o,
    input logic                             out_ready_i,
    input logic [mist_video_pkg::VID_W-1:0] out_r_o,
    input logic [mist_video_pkg::VID_W-1:0] out_g_o,
    input logic [mist_video_pkg::VID_W-1:0] out_b_o,
    input logic                             out_hs_o,
    input logic                             out_vs_o
);
    timeunit 1ns;
    timeprecision 100ps;

    // a stalled pixel stays put until the sink takes it
    a_out_stable: assert property (@(posedge clk_sys) disable iff (rst_i)
        out_valid_o && !out_ready_i |=> out_valid_o &&
        $stable({out_r_o, out_g_o, out_b_o, out_hs_o, out_vs_o}))
        else $error("output changed while stalled");

    a_valid_reset: assert property (@(posedge clk_sys) rst_i |=> !out_valid_o)
        else $error("out_valid_o high after reset");

    a_ready_reset: assert property (@(posedge clk_sys) rst_i |=> in_ready_o)
        else $error("in_ready_o low after reset");

endmodule

bind mist_video_out mist_video_out_props i_mist_video_out_props (
    .clk_sys     (clk_sys),
    .rst_i       (rst_i),
    .in_ready_o  (in_ready_o),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .out_r_o     (out_r_o),
    .out_g_o     (out_g_o),
    .out_b_o     (out_b_o),
    .out_hs_o    (out_hs_o),
    .out_vs_o    (out_vs_o)
);

// File: design/mist_video_out.sv
//****************************************
// mist_video_out
// video output path: OSD window, three
// colour channels and the output encoder
//****************************************

module mist_video_out #(
    parameter int COLORW = 4,
    parameter int OSD_X  = 8,
    parameter int OSD_Y  = 4
) (
    input  logic                                 clk_sys,
    input  logic                                 rst_i,
    // game pixels
    input  logic                                 in_valid_i,
    output logic                                 in_ready_o,
    input  logic [COLORW-1:0]                    in_r_i,
    input  logic [COLORW-1:0]                    in_g_i,
    input  logic [COLORW-1:0]                    in_b_i,
    input  logic                                 in_hs_i,
    input  logic                                 in_vs_i,
    // quasi-static control
    input  mist_video_pkg::out_mode_e            out_mode_i,
    input  logic                                 csync_i,
    input  logic                                 osd_enable_i,
    // OSD bitmap write
    input  logic                                 osd_wr_i,
    input  logic [mist_video_pkg::OSD_ROW_W-1:0] osd_row_i,
    input  logic [mist_video_pkg::OSD_W-1:0]     osd_bits_i,
    // video out
    output logic                                 out_valid_o,
    input  logic                                 out_ready_i,
    output logic [mist_video_pkg::VID_W-1:0]     out_r_o,
    output logic [mist_video_pkg::VID_W-1:0]     out_g_o,
    output logic [mist_video_pkg::VID_W-1:0]     out_b_o,
    output logic                                 out_hs_o,
    output logic                                 out_vs_o
);

    localparam int VW   = mist_video_pkg::VID_W;
    localparam int N_CH = int'(mist_video_pkg::CH_B) + 1;

    logic              w_valid;
    logic              w_hs;
    logic              w_vs;
    logic              w_hit;
    logic              w_osd_bit;
    logic [COLORW-1:0] w_comp [N_CH];
    logic [VW-1:0]     c_comp [N_CH];
    logic              c_valid_q;
    logic              c_hs_q;
    logic              c_vs_q;
    logic              c_ready;
    logic              c_load;
    logic              e_ready;

    osd_window #(
        .COLORW (COLORW),
        .OSD_X  (OSD_X),
        .OSD_Y  (OSD_Y)
    ) i_osd_window (
        .clk_sys      (clk_sys),
        .rst_i        (rst_i),
        .in_valid_i   (in_valid_i),
        .in_ready_o   (in_ready_o),
        .in_r_i       (in_r_i),
        .in_g_i       (in_g_i),
        .in_b_i       (in_b_i),
        .in_hs_i      (in_hs_i),
        .in_vs_i      (in_vs_i),
        .osd_enable_i (osd_enable_i),
        .osd_wr_i     (osd_wr_i),
        .osd_row_i    (osd_row_i),
        .osd_bits_i   (osd_bits_i),
        .w_valid_o    (w_valid),
        .w_ready_i    (c_ready),
        .w_r_o        (w_comp[mist_video_pkg::CH_R]),
        .w_g_o        (w_comp[mist_video_pkg::CH_G]),
        .w_b_o        (w_comp[mist_video_pkg::CH_B]),
        .w_hs_o       (w_hs),
        .w_vs_o       (w_vs),
        .hit_o        (w_hit),
        .osd_bit_o    (w_osd_bit)
    );

    // the channels advance together on one enable
    assign c_ready = !c_valid_q || e_ready;
    assign c_load  = w_valid && c_ready;

    always_ff @(posedge clk_sys) begin
        if (rst_i) begin
            c_valid_q <= 1'b0;
        end else if (c_ready) begin
            c_valid_q <= w_valid;
        end
    end

    // syncs ride alongside the channel registers
    always_ff @(posedge clk_sys) begin
        if (c_load) begin
            c_hs_q <= w_hs;
            c_vs_q <= w_vs;
        end
    end

    for (genvar ch = 0; ch < N_CH; ch++) begin : g_chan
        localparam logic [VW-1:0] TINT =
            (ch == int'(mist_video_pkg::CH_R)) ? mist_video_pkg::OSD_TINT_R :
            (ch == int'(mist_video_pkg::CH_G)) ? mist_video_pkg::OSD_TINT_G :
                                                 mist_video_pkg::OSD_TINT_B;

        osd_channel #(
            .COLORW (COLORW),
            .TINT   (TINT)
        ) i_osd_channel (
            .clk_sys   (clk_sys),
            .rst_i     (rst_i),
            .load_i    (c_load),
            .comp_i    (w_comp[ch]),
            .hit_i     (w_hit),
            .osd_bit_i (w_osd_bit),
            .comp_o    (c_comp[ch])
        );
    end

    video_encoder i_video_encoder (
        .clk_sys     (clk_sys),
        .rst_i       (rst_i),
        .c_valid_i   (c_valid_q),
        .c_ready_o   (e_ready),
        .c_r_i       (c_comp[mist_video_pkg::CH_R]),
        .c_g_i       (c_comp[mist_video_pkg::CH_G]),
        .c_b_i       (c_comp[mist_video_pkg::CH_B]),
        .c_hs_i      (c_hs_q),
        .c_vs_i      (c_vs_q),
        .out_mode_i  (out_mode_i),
        .csync_i     (csync_i),
        .out_valid_o (out_valid_o),
        .out_ready_i (out_ready_i),
        .out_r_o     (out_r_o),
        .out_g_o     (out_g_o),
        .out_b_o     (out_b_o),
        .out_hs_o    (out_hs_o),
        .out_vs_o    (out_vs_o)
    );

endmodule

// File: design/video_encoder.sv
//****************************************
// video_encoder
// optional RGB to YPbPr conversion, sync
// formatting and the output register
//****************************************

module video_encoder (
    input  logic                              clk_sys,
    input  logic                              rst_i,
    // channel stage
    input  logic                              c_valid_i,
    output logic                              c_ready_o,
    input  logic [mist_video_pkg::VID_W-1:0]  c_r_i,
    input  logic [mist_video_pkg::VID_W-1:0]  c_g_i,
    input  logic [mist_video_pkg::VID_W-1:0]  c_b_i,
    input  logic                              c_hs_i,
    input  logic                              c_vs_i,
    // control
    input  mist_video_pkg::out_mode_e         out_mode_i,
    input  logic                              csync_i,
    // video out
    output logic                              out_valid_o,
    input  logic                              out_ready_i,
    output logic [mist_video_pkg::VID_W-1:0]  out_r_o,
    output logic [mist_video_pkg::VID_W-1:0]  out_g_o,
    output logic [mist_video_pkg::VID_W-1:0]  out_b_o,
    output logic                              out_hs_o,
    output logic                              out_vs_o
);

    localparam int VW = mist_video_pkg::VID_W;

    logic                       out_valid_q;
    logic                       load;
    logic [8:0]                 y_sum;
    logic [VW-1:0]              y_val;
    logic signed [7:0]          b_diff;
    logic signed [7:0]          r_diff;
    logic signed [7:0]          pb_raw;
    logic signed [7:0]          pr_raw;
    logic [VW-1:0]              pb_val;
    logic [VW-1:0]              pr_val;
    mist_video_pkg::sync_mode_e sync_mode;
    logic [VW-1:0]              r_nxt;
    logic [VW-1:0]              g_nxt;
    logic [VW-1:0]              b_nxt;
    logic                       hs_nxt;
    logic                       vs_nxt;

    // limit a signed value to the 6-bit range
    function automatic logic [VW-1:0] clamp6(input logic signed [7:0] v);
        logic [VW-1:0] res;
        if (v < 0) begin
            res = '0;
        end else if (v > 8'sd63) begin
            res = '1;
        end else begin
            res = v[VW-1:0];
        end
        return res;
    endfunction

    assign c_ready_o   = !out_valid_q || out_ready_i;
    assign load        = c_valid_i && c_ready_o;
    assign out_valid_o = out_valid_q;

    // Y = (2R + 5G + B) / 8
    assign y_sum = 9'({c_r_i, 1'b0}) + 9'(c_g_i) * 9'd5 + 9'(c_b_i);
    assign y_val = y_sum[8:3];

    // colour differences around mid scale
    assign b_diff = $signed({2'b00, c_b_i}) - $signed({2'b00, y_val});
    assign r_diff = $signed({2'b00, c_r_i}) - $signed({2'b00, y_val});
    assign pb_raw = 8'sd32 + (b_diff >>> 1);
    assign pr_raw = 8'sd32 + (r_diff >>> 1);
    assign pb_val = clamp6(pb_raw);
    assign pr_val = clamp6(pr_raw);

    // a SCART cable wants csync on hs and a high vs
    assign sync_mode = (out_mode_i == mist_video_pkg::MODE_YPBPR || csync_i) ?
                       mist_video_pkg::SYNC_COMPOSITE : mist_video_pkg::SYNC_SEPARATE;

    always_comb begin
        if (out_mode_i == mist_video_pkg::MODE_YPBPR) begin
            r_nxt = pr_val;
            g_nxt = y_val;
            b_nxt = pb_val;
        end else begin
            r_nxt = c_r_i;
            g_nxt = c_g_i;
            b_nxt = c_b_i;
        end
        if (sync_mode == mist_video_pkg::SYNC_COMPOSITE) begin
            hs_nxt = ~(c_hs_i ^ c_vs_i);
            vs_nxt = 1'b1;
        end else begin
            hs_nxt = c_hs_i;
            vs_nxt = c_vs_i;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (rst_i) begin
            out_valid_q <= 1'b0;
        end else if (c_ready_o) begin
            out_valid_q <= c_valid_i;
        end
    end

    // output holds while the sink stalls
    always_ff @(posedge clk_sys) begin
        if (load) begin
            out_r_o  <= r_nxt;
            out_g_o  <= g_nxt;
            out_b_o  <= b_nxt;
            out_hs_o <= hs_nxt;
            out_vs_o <= vs_nxt;
        end
    end

endmodule

// File: design/osd_channel.sv
//****************************************
// osd_channel
// widens one colour component to 6 bits and
// applies the OSD overlay
//****************************************

module osd_channel #(
    parameter int                                COLORW = 4,
    parameter logic [mist_video_pkg::VID_W-1:0] TINT   = 6'h3f
) (
    input  logic                             clk_sys,
    input  logic                             rst_i,
    input  logic                             load_i,
    input  logic [COLORW-1:0]                comp_i,
    input  logic                             hit_i,
    input  logic                             osd_bit_i,
    output logic [mist_video_pkg::VID_W-1:0] comp_o
);

    localparam int VW = mist_video_pkg::VID_W;

    logic [2*COLORW-1:0] rep;
    logic [VW-1:0]       wide;
    logic [VW-1:0]       mixed;

    // top bits repeat into the low end; wide inputs lose their low bits
    assign rep  = {comp_i, comp_i};
    assign wide = rep[2*COLORW-1 -: VW];

    always_comb begin
        if (hit_i && osd_bit_i) begin
            mixed = TINT;
        end else if (hit_i) begin
            // darken the game behind the OSD
            mixed = wide >> 1;
        end else begin
            mixed = wide;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (rst_i) begin
            comp_o <= '0;
        end else if (load_i) begin
            comp_o <= mixed;
        end
    end

endmodule

// File: design/osd_window.sv
//****************************************
// osd_window
// pixel ingress stage, screen position
// tracking, OSD bitmap and window hit test
//****************************************

module osd_window #(
    parameter int COLORW = 4,
    parameter int OSD_X  = 8,
    parameter int OSD_Y  = 4
) (
    input  logic                                 clk_sys,
    input  logic                                 rst_i,
    // pixel stream from the core
    input  logic                                 in_valid_i,
    output logic                                 in_ready_o,
    input  logic [COLORW-1:0]                    in_r_i,
    input  logic [COLORW-1:0]                    in_g_i,
    input  logic [COLORW-1:0]                    in_b_i,
    input  logic                                 in_hs_i,
    input  logic                                 in_vs_i,
    // OSD control and bitmap load
    input  logic                                 osd_enable_i,
    input  logic                                 osd_wr_i,
    input  logic [mist_video_pkg::OSD_ROW_W-1:0] osd_row_i,
    input  logic [mist_video_pkg::OSD_W-1:0]     osd_bits_i,
    // window stage towards the channels
    output logic                                 w_valid_o,
    input  logic                                 w_ready_i,
    output logic [COLORW-1:0]                    w_r_o,
    output logic [COLORW-1:0]                    w_g_o,
    output logic [COLORW-1:0]                    w_b_o,
    output logic                                 w_hs_o,
    output logic                                 w_vs_o,
    output logic                                 hit_o,
    output logic                                 osd_bit_o
);

    // position counter widths, enough for common arcade timings
    localparam int X_W   = 11;
    localparam int Y_W   = 10;
    localparam int COL_W = $clog2(mist_video_pkg::OSD_W);

    logic                             w_valid_q;
    logic                             accept;
    logic [X_W-1:0]                   x_q;
    logic [Y_W-1:0]                   y_q;
    logic [X_W-1:0]                   dx;
    logic [Y_W-1:0]                   dy;
    logic                             in_x;
    logic                             in_y;
    logic                             hit;
    logic [mist_video_pkg::OSD_W-1:0] bitmap_q [mist_video_pkg::OSD_H];
    logic [mist_video_pkg::OSD_W-1:0] row_bits;

    // stage loads when empty or when its pixel leaves this cycle
    assign in_ready_o = !w_valid_q || w_ready_i;
    assign accept     = in_valid_i && in_ready_o;
    assign w_valid_o  = w_valid_q;

    // offset of the entering pixel inside the window
    assign dx = x_q - X_W'(OSD_X);
    assign dy = y_q - Y_W'(OSD_Y);

    assign in_x = (x_q >= X_W'(OSD_X)) && (x_q < X_W'(OSD_X + mist_video_pkg::OSD_W));
    assign in_y = (y_q >= Y_W'(OSD_Y)) && (y_q < Y_W'(OSD_Y + mist_video_pkg::OSD_H));
    assign hit  = osd_enable_i && in_x && in_y;

    assign row_bits = bitmap_q[dy[mist_video_pkg::OSD_ROW_W-1:0]];

    // bitmap write port, read by the next entering pixel
    always_ff @(posedge clk_sys) begin
        if (osd_wr_i) begin
            bitmap_q[osd_row_i] <= osd_bits_i;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (rst_i) begin
            w_valid_q <= 1'b0;
        end else if (in_ready_o) begin
            w_valid_q <= in_valid_i;
        end
    end

    // x and y follow accepted pixels, saturating off screen
    always_ff @(posedge clk_sys) begin
        if (rst_i) begin
            x_q <= '0;
            y_q <= '0;
        end else if (accept) begin
            if (in_hs_i) begin
                x_q <= '0;
            end else if (x_q != '1) begin
                x_q <= x_q + 1'b1;
            end
            // vs wins over a line step
            if (in_vs_i) begin
                y_q <= '0;
            end else if (in_hs_i && y_q != '1) begin
                y_q <= y_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_sys) begin
        if (accept) begin
            w_r_o     <= in_r_i;
            w_g_o     <= in_g_i;
            w_b_o     <= in_b_i;
            w_hs_o    <= in_hs_i;
            w_vs_o    <= in_vs_i;
            hit_o     <= hit;
            osd_bit_o <= hit && row_bits[dx[COL_W-1:0]];
        end
    end

endmodule

// File: design/mist_video_pkg.sv
//****************************************
// mist video package
// widths, enums and OSD constants shared by
// the video output blocks
//****************************************

package mist_video_pkg;

    // output colour component width
    localparam int VID_W = 6;

    // OSD window size
    localparam int OSD_W = 16;
    localparam int OSD_H = 8;

    // bitmap row index
    localparam int OSD_ROW_W = 3;

    typedef enum logic {
        MODE_RGB   = 1'b0,
        MODE_YPBPR = 1'b1
    } out_mode_e;

    typedef enum logic {
        SYNC_SEPARATE  = 1'b0,
        SYNC_COMPOSITE = 1'b1
    } sync_mode_e;

    // channel identity, also the generate index
    typedef enum logic [1:0] {
        CH_R = 2'd0,
        CH_G = 2'd1,
        CH_B = 2'd2
    } chan_e;

    // OSD foreground, a light green
    localparam logic [VID_W-1:0] OSD_TINT_R = 6'h01;
    localparam logic [VID_W-1:0] OSD_TINT_G = 6'h3f;
    localparam logic [VID_W-1:0] OSD_TINT_B = 6'h01;

endpackage
